/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ctrl_top
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* alu_op_decoder.sv */
`include "rv_ctrl_params.svh"

module alu_op_decoder (
        input  rv_ctrl_pkg::inst_u inst,
        ctrl_if.funct              ctl
);
        logic [2:0] f3;
        logic [6:0] f7_chk;
        logic       is_reg;
        logic       is_word;
        logic       checked;
        logic       alt_ok;

        function automatic rv_ctrl_pkg::alu_sel_e alu_of(input logic [2:0] funct3,
                                                         input logic alt, input logic word);
                rv_ctrl_pkg::alu_sel_e sel;
                case (funct3)
                        3'b000:  sel = alt ? rv_ctrl_pkg::alu_sub : rv_ctrl_pkg::alu_add;
                        3'b001:  sel = rv_ctrl_pkg::alu_sll;
                        3'b010:  sel = rv_ctrl_pkg::alu_lt;
                        3'b011:  sel = rv_ctrl_pkg::alu_ltu;
                        3'b100:  sel = rv_ctrl_pkg::alu_xor;
                        3'b101:  sel = alt ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
                        3'b110:  sel = rv_ctrl_pkg::alu_or;
                        default: sel = rv_ctrl_pkg::alu_and;
                endcase
                if (word) begin
                        case (sel)
                                rv_ctrl_pkg::alu_add: sel = rv_ctrl_pkg::alu_addw;
                                rv_ctrl_pkg::alu_sub: sel = rv_ctrl_pkg::alu_subw;
                                rv_ctrl_pkg::alu_sll: sel = rv_ctrl_pkg::alu_sllw;
                                rv_ctrl_pkg::alu_srl: sel = rv_ctrl_pkg::alu_srlw;
                                rv_ctrl_pkg::alu_sra: sel = rv_ctrl_pkg::alu_sraw;
                                default: ;
                        endcase
                end
                return sel;
        endfunction

        assign f3      = inst.r.funct3;
        assign is_reg  = ctl.op_class inside {rv_ctrl_pkg::cls_op, rv_ctrl_pkg::cls_op_32};
        assign is_word = ctl.op_class inside {rv_ctrl_pkg::cls_op_32,
                                              rv_ctrl_pkg::cls_op_imm_32};
        assign checked = is_reg || f3 == 3'b001 || f3 == 3'b101; // funct7 is meaningful
        assign alt_ok  = f3 == 3'b101 || (f3 == 3'b000 && is_reg);
        // rv64 shamt is 6 bits, so bit 25 is not funct7 here
        assign f7_chk  = (ctl.op_class == rv_ctrl_pkg::cls_op_imm) ?
                         {inst.r.funct7[6:1], 1'b0} : inst.r.funct7;

        always_comb begin
                ctl.alu_sel   = rv_ctrl_pkg::alu_add;
                ctl.mem_r_sel = rv_ctrl_pkg::mr_b;
                ctl.mem_mask  = '0;
                ctl.funct_bad = 1'b0;
                case (ctl.op_class)
                        rv_ctrl_pkg::cls_op, rv_ctrl_pkg::cls_op_32,
                        rv_ctrl_pkg::cls_op_imm, rv_ctrl_pkg::cls_op_imm_32: begin
                                ctl.alu_sel   = alu_of(f3, checked && f7_chk == `RV_F7_ALT,
                                                       is_word);
                                ctl.funct_bad = checked && !(f7_chk == `RV_F7_BASE ||
                                                (f7_chk == `RV_F7_ALT && alt_ok));
                                if (is_word && !(f3 inside {3'b000, 3'b001, 3'b101}))
                                        ctl.funct_bad = 1'b1; // no W form
                        end
                        rv_ctrl_pkg::cls_load: begin
                                if (inst.i.funct3 == 3'b111)
                                        ctl.funct_bad = 1'b1;
                                else
                                        ctl.mem_r_sel = rv_ctrl_pkg::mem_r_sel_e'(inst.i.funct3);
                        end
                        rv_ctrl_pkg::cls_store: begin
                                case (inst.s.funct3)
                                        3'b000:  ctl.mem_mask = `RV_MASK_B;
                                        3'b001:  ctl.mem_mask = `RV_MASK_H;
                                        3'b010:  ctl.mem_mask = `RV_MASK_W;
                                        3'b011:  ctl.mem_mask = `RV_MASK_D;
                                        default: ctl.funct_bad = 1'b1;
                                endcase
                        end
                        rv_ctrl_pkg::cls_branch: begin
                                ctl.funct_bad = inst.b.funct3[2:1] == 2'b01;
                        end
                        default: ; // address forms keep add
                endcase
        end
endmodule

/* ctrl_if.sv */
interface ctrl_if;
        rv_ctrl_pkg::op_class_e  op_class;
        rv_ctrl_pkg::imm_sel_e   imm_sel;
        rv_ctrl_pkg::alu_a_sel_e alu_a_sel;
        rv_ctrl_pkg::alu_b_sel_e alu_b_sel;
        rv_ctrl_pkg::reg_w_sel_e reg_w_sel;
        rv_ctrl_pkg::pc_sel_e    pc_sel;
        logic                    reg_wen;
        logic                    mem_wen;
        logic                    mem_ren;
        logic                    ebreak;
        rv_ctrl_pkg::alu_sel_e   alu_sel;
        rv_ctrl_pkg::mem_r_sel_e mem_r_sel;
        logic [7:0]              mem_mask;
        logic                    funct_bad; // funct3/funct7 not in the base set

        modport main (
                output op_class, imm_sel, alu_a_sel, alu_b_sel, reg_w_sel, pc_sel,
                       reg_wen, mem_wen, mem_ren, ebreak
        );

        modport funct (
                input  op_class,
                output alu_sel, mem_r_sel, mem_mask, funct_bad
        );

        modport sink (
                input op_class, imm_sel, alu_a_sel, alu_b_sel, reg_w_sel, pc_sel, reg_wen,
                      mem_wen, mem_ren, ebreak, alu_sel, mem_r_sel, mem_mask, funct_bad
        );
endinterface

/* ctrl_sva.sv */
module ctrl_sva (
        input logic clk,
        input logic rst_n,
        input logic req,
        input logic ack,
        input logic illegal,
        input logic reg_wen,
        input logic mem_wen,
        input logic mem_ren,
        input logic ebreak
);
        ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
                $rose(ack) |-> $past(req))
                else $error("ack rose without a request");

        ack_after_drop: assert property (@(posedge clk) disable iff (!rst_n)
                $fell(ack) |-> !$past(req))
                else $error("ack fell while req was still high");

        illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                illegal |-> !(reg_wen || mem_wen || mem_ren || ebreak))
                else $error("illegal word left an enable high");

        wen_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                !(reg_wen && mem_wen))
                else $error("reg_wen and mem_wen high together");
endmodule

bind decode_handshake ctrl_sva u_ctrl_sva (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ack     (ack),
        .illegal (illegal),
        .reg_wen (reg_wen),
        .mem_wen (mem_wen),
        .mem_ren (mem_ren),
        .ebreak  (ebreak)
);

/* ctrl_top.sv */
`include "rv_ctrl_params.svh"

module ctrl_top (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    req,
        output logic                    ack,
        input  logic [`RV_INST_W-1:0]   inst,
        input  logic                    b_eq,
        input  logic                    b_lt,
        input  logic                    b_ltu,
        output rv_ctrl_pkg::pc_sel_e    pc_sel,
        output rv_ctrl_pkg::imm_sel_e   imm_sel,
        output rv_ctrl_pkg::alu_sel_e   alu_sel,
        output rv_ctrl_pkg::alu_a_sel_e alu_a_sel,
        output rv_ctrl_pkg::alu_b_sel_e alu_b_sel,
        output rv_ctrl_pkg::mem_r_sel_e mem_r_sel,
        output rv_ctrl_pkg::reg_w_sel_e reg_w_sel,
        output logic [7:0]              mem_mask,
        output logic                    reg_wen,
        output logic                    mem_wen,
        output logic                    mem_ren,
        output logic                    ebreak,
        output logic                    illegal
);
        ctrl_if ctl ();

        opcode_decoder u_opcode_decoder (
                .inst  (inst),
                .b_eq  (b_eq),
                .b_lt  (b_lt),
                .b_ltu (b_ltu),
                .ctl   (ctl.main)
        );

        alu_op_decoder u_alu_op_decoder (
                .inst (inst),
                .ctl  (ctl.funct)
        );

        decode_handshake u_decode_handshake (
                .clk       (clk),
                .rst_n     (rst_n),
                .req       (req),
                .ack       (ack),
                .ctl       (ctl.sink),
                .pc_sel    (pc_sel),
                .imm_sel   (imm_sel),
                .alu_sel   (alu_sel),
                .alu_a_sel (alu_a_sel),
                .alu_b_sel (alu_b_sel),
                .mem_r_sel (mem_r_sel),
                .reg_w_sel (reg_w_sel),
                .mem_mask  (mem_mask),
                .reg_wen   (reg_wen),
                .mem_wen   (mem_wen),
                .mem_ren   (mem_ren),
                .ebreak    (ebreak),
                .illegal   (illegal)
        );
endmodule

/* decode_handshake.sv */
module decode_handshake (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    req,
        output logic                    ack,
        ctrl_if.sink                    ctl,
        output rv_ctrl_pkg::pc_sel_e    pc_sel,
        output rv_ctrl_pkg::imm_sel_e   imm_sel,
        output rv_ctrl_pkg::alu_sel_e   alu_sel,
        output rv_ctrl_pkg::alu_a_sel_e alu_a_sel,
        output rv_ctrl_pkg::alu_b_sel_e alu_b_sel,
        output rv_ctrl_pkg::mem_r_sel_e mem_r_sel,
        output rv_ctrl_pkg::reg_w_sel_e reg_w_sel,
        output logic [7:0]              mem_mask,
        output logic                    reg_wen,
        output logic                    mem_wen,
        output logic                    mem_ren,
        output logic                    ebreak,
        output logic                    illegal
);
        logic bad;
        logic capture;

        assign bad     = ctl.op_class == rv_ctrl_pkg::cls_bad || ctl.funct_bad;
        assign capture = req && !ack; // new request, not yet acknowledged

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        ack       <= 1'b0;
                        pc_sel    <= rv_ctrl_pkg::pc_snpc;
                        imm_sel   <= rv_ctrl_pkg::imm_i;
                        alu_sel   <= rv_ctrl_pkg::alu_add;
                        alu_a_sel <= rv_ctrl_pkg::a_rs1;
                        alu_b_sel <= rv_ctrl_pkg::b_rs2;
                        mem_r_sel <= rv_ctrl_pkg::mr_b;
                        reg_w_sel <= rv_ctrl_pkg::w_alu;
                        mem_mask  <= '0;
                        reg_wen   <= 1'b0;
                        mem_wen   <= 1'b0;
                        mem_ren   <= 1'b0;
                        ebreak    <= 1'b0;
                        illegal   <= 1'b0;
                end else begin
                        ack <= req; // rises one edge after req, falls one edge after drop
                        if (capture) begin
                                pc_sel    <= bad ? rv_ctrl_pkg::pc_snpc : ctl.pc_sel;
                                imm_sel   <= ctl.imm_sel;
                                alu_sel   <= ctl.alu_sel;
                                alu_a_sel <= ctl.alu_a_sel;
                                alu_b_sel <= ctl.alu_b_sel;
                                mem_r_sel <= ctl.mem_r_sel;
                                reg_w_sel <= ctl.reg_w_sel;
                                mem_mask  <= ctl.mem_mask;
                                reg_wen   <= ctl.reg_wen && !bad;
                                mem_wen   <= ctl.mem_wen && !bad;
                                mem_ren   <= ctl.mem_ren && !bad;
                                ebreak    <= ctl.ebreak && !bad;
                                illegal   <= bad;
                        end
                end
        end
endmodule

/* opcode_decoder.sv */
`include "rv_ctrl_params.svh"

module opcode_decoder (
        input  rv_ctrl_pkg::inst_u inst,
        input  logic               b_eq,
        input  logic               b_lt,
        input  logic               b_ltu,
        ctrl_if.main               ctl
);
        logic taken;

        always_comb begin
                case (inst.b.funct3)
                        3'b000:  taken = b_eq;
                        3'b001:  taken = !b_eq;
                        3'b100:  taken = b_lt;
                        3'b101:  taken = !b_lt;
                        3'b110:  taken = b_ltu;
                        3'b111:  taken = !b_ltu;
                        default: taken = 1'b0; // 010/011 rejected in funct decode
                endcase
        end

        always_comb begin
                ctl.op_class  = rv_ctrl_pkg::cls_bad;
                ctl.imm_sel   = rv_ctrl_pkg::imm_i;
                ctl.alu_a_sel = rv_ctrl_pkg::a_rs1;
                ctl.alu_b_sel = rv_ctrl_pkg::b_imm;
                ctl.reg_w_sel = rv_ctrl_pkg::w_alu;
                ctl.pc_sel    = rv_ctrl_pkg::pc_snpc;
                ctl.reg_wen   = 1'b0;
                ctl.mem_wen   = 1'b0;
                ctl.mem_ren   = 1'b0;
                ctl.ebreak    = 1'b0;
                case (inst.u.opcode)
                        `RV_OPC_OP, `RV_OPC_OP_32: begin
                                ctl.op_class  = (inst.r.opcode == `RV_OPC_OP) ?
                                                rv_ctrl_pkg::cls_op : rv_ctrl_pkg::cls_op_32;
                                ctl.alu_b_sel = rv_ctrl_pkg::b_rs2;
                                ctl.reg_wen   = 1'b1;
                        end
                        `RV_OPC_OP_IMM, `RV_OPC_OP_IMM_32: begin
                                ctl.op_class = (inst.i.opcode == `RV_OPC_OP_IMM) ?
                                               rv_ctrl_pkg::cls_op_imm :
                                               rv_ctrl_pkg::cls_op_imm_32;
                                ctl.reg_wen  = 1'b1;
                        end
                        `RV_OPC_LOAD: begin
                                ctl.op_class  = rv_ctrl_pkg::cls_load;
                                ctl.reg_w_sel = rv_ctrl_pkg::w_mem;
                                ctl.reg_wen   = 1'b1;
                                ctl.mem_ren   = 1'b1;
                        end
                        `RV_OPC_STORE: begin
                                ctl.op_class = rv_ctrl_pkg::cls_store;
                                ctl.imm_sel  = rv_ctrl_pkg::imm_s;
                                ctl.mem_wen  = 1'b1;
                        end
                        `RV_OPC_BRANCH: begin
                                ctl.op_class  = rv_ctrl_pkg::cls_branch;
                                ctl.imm_sel   = rv_ctrl_pkg::imm_sb;
                                ctl.alu_a_sel = rv_ctrl_pkg::a_pc; // target = pc + imm
                                ctl.pc_sel    = taken ? rv_ctrl_pkg::pc_alu :
                                                        rv_ctrl_pkg::pc_snpc;
                        end
                        `RV_OPC_JAL: begin
                                ctl.op_class  = rv_ctrl_pkg::cls_jal;
                                ctl.imm_sel   = rv_ctrl_pkg::imm_uj;
                                ctl.alu_a_sel = rv_ctrl_pkg::a_pc;
                                ctl.reg_w_sel = rv_ctrl_pkg::w_pc; // link address
                                ctl.pc_sel    = rv_ctrl_pkg::pc_alu;
                                ctl.reg_wen   = 1'b1;
                        end
                        `RV_OPC_JALR: begin
                                ctl.op_class  = rv_ctrl_pkg::cls_jalr;
                                ctl.reg_w_sel = rv_ctrl_pkg::w_pc;
                                ctl.pc_sel    = rv_ctrl_pkg::pc_alu;
                                ctl.reg_wen   = 1'b1;
                        end
                        `RV_OPC_LUI, `RV_OPC_AUIPC: begin
                                ctl.op_class  = (inst.u.opcode == `RV_OPC_LUI) ?
                                                rv_ctrl_pkg::cls_lui : rv_ctrl_pkg::cls_auipc;
                                ctl.imm_sel   = rv_ctrl_pkg::imm_u;
                                ctl.alu_a_sel = (inst.u.opcode == `RV_OPC_LUI) ?
                                                rv_ctrl_pkg::a_zero : rv_ctrl_pkg::a_pc;
                                ctl.reg_wen   = 1'b1;
                        end
                        `RV_OPC_SYSTEM: begin
                                if (inst == `RV_EBREAK_WORD) begin // only ebreak supported
                                        ctl.op_class = rv_ctrl_pkg::cls_system;
                                        ctl.ebreak   = 1'b1;
                                end
                        end
                        default: begin
                                if (inst == '0)
                                        ctl.op_class = rv_ctrl_pkg::cls_none; // bubble
                        end
                endcase
        end
endmodule

/* rv_ctrl_params.svh */
`ifndef RV_CTRL_PARAMS_SVH
`define RV_CTRL_PARAMS_SVH

`define RV_INST_W 32

`define RV_OPC_OP        7'b0110011
`define RV_OPC_OP_32     7'b0111011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_OP_IMM_32 7'b0011011
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_JAL       7'b1101111
`define RV_OPC_JALR      7'b1100111
`define RV_OPC_LUI       7'b0110111
`define RV_OPC_AUIPC     7'b0010111
`define RV_OPC_SYSTEM    7'b1110011

`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

`define RV_EBREAK_WORD 32'h0010_0073

`define RV_MASK_B 8'h01
`define RV_MASK_H 8'h03
`define RV_MASK_W 8'h0f
`define RV_MASK_D 8'hff

`endif

/* rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

        typedef struct packed {
                logic [6:0] funct7;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] rd;
                logic [6:0] opcode;
        } r_t;

        typedef struct packed {
                logic [11:0] imm; // shamt and shift funct7 live here too
                logic [4:0]  rs1;
                logic [2:0]  funct3;
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } i_t;

        typedef struct packed {
                logic [6:0] imm_hi;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] imm_lo;
                logic [6:0] opcode;
        } s_t;

        typedef struct packed {
                logic       imm12;
                logic [5:0] imm10_5;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [3:0] imm4_1;
                logic       imm11;
                logic [6:0] opcode;
        } b_t;

        typedef struct packed {
                logic [19:0] imm;
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } u_t;

        typedef struct packed {
                logic       imm20;
                logic [9:0] imm10_1;
                logic       imm11;
                logic [7:0] imm19_12;
                logic [4:0] rd;
                logic [6:0] opcode;
        } j_t;

        typedef union packed {
                r_t r;
                i_t i;
                s_t s;
                b_t b;
                u_t u;
                j_t j;
        } inst_u;

        typedef enum logic [3:0] {
                cls_none, cls_op, cls_op_32, cls_op_imm, cls_op_imm_32, cls_load, cls_store,
                cls_branch, cls_jal, cls_jalr, cls_lui, cls_auipc, cls_system, cls_bad
        } op_class_e;

        typedef enum logic [4:0] {
                alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra,
                alu_lt, alu_ltu, alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw
        } alu_sel_e;

        typedef enum logic [2:0] {imm_i, imm_s, imm_sb, imm_u, imm_uj} imm_sel_e;
        typedef enum logic [1:0] {a_rs1, a_pc, a_zero} alu_a_sel_e;
        typedef enum logic [0:0] {b_rs2, b_imm} alu_b_sel_e;
        typedef enum logic [1:0] {w_alu, w_mem, w_pc} reg_w_sel_e;
        typedef enum logic [2:0] {mr_b, mr_h, mr_w, mr_d, mr_bu, mr_hu, mr_wu} mem_r_sel_e;
        typedef enum logic [0:0] {pc_snpc, pc_alu} pc_sel_e;

endpackage

/* tb_ctrl_top.sv */
`include "rv_ctrl_params.svh"

module tb_ctrl_top;
        localparam int N_TESTS = 56;
        localparam int LIMIT   = N_TESTS * 8 + 5 + 20;

        localparam logic [31:0] FX_R   = 32'hfe00_707f; // funct7, funct3, opcode
        localparam logic [31:0] FX_SH  = 32'hfc00_707f; // bit 25 is shamt on rv64
        localparam logic [31:0] FX_I   = 32'h0000_707f;
        localparam logic [31:0] FX_U   = 32'h0000_007f;
        localparam logic [31:0] FX_ALL = 32'hffff_ffff;
        localparam logic [35:0] DC     = '1; // selects not compared

        logic                    clk;
        logic                    rst_n;
        logic                    req;
        logic                    ack;
        logic [`RV_INST_W-1:0]   inst;
        logic                    b_eq;
        logic                    b_lt;
        logic                    b_ltu;
        rv_ctrl_pkg::pc_sel_e    pc_sel;
        rv_ctrl_pkg::imm_sel_e   imm_sel;
        rv_ctrl_pkg::alu_sel_e   alu_sel;
        rv_ctrl_pkg::alu_a_sel_e alu_a_sel;
        rv_ctrl_pkg::alu_b_sel_e alu_b_sel;
        rv_ctrl_pkg::mem_r_sel_e mem_r_sel;
        rv_ctrl_pkg::reg_w_sel_e reg_w_sel;
        logic [7:0]              mem_mask;
        logic                    reg_wen;
        logic                    mem_wen;
        logic                    mem_ren;
        logic                    ebreak;
        logic                    illegal;

        string       names [N_TESTS];
        logic [31:0] bases [N_TESTS];
        logic [31:0] fixeds [N_TESTS];
        logic [2:0]  flags [N_TESTS];
        logic [35:0] sels [N_TESTS];
        logic [5:0]  ens [N_TESTS];
        int          n_tab;
        int          cycles;
        logic [31:0] lfsr;

        ctrl_top u_ctrl_top (.*);

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        initial begin
                cycles = 0;
                while (cycles < LIMIT) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("timeout after %0d cycles, handshake never completed", cycles);
                $display("Regression failed");
                $fatal(1, "simulation stopped by the cycle limit");
        end

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
        endfunction

        task automatic random_word(output logic [31:0] w);
                w = '0;
                for (int b = 0; b < 32; b++) begin
                        lfsr = lfsr_step(lfsr);
                        w    = {w[30:0], lfsr[0]};
                end
        endtask

        function automatic logic [35:0] sel_vec();
                return {3'b0, alu_sel, 1'b0, imm_sel, 2'b0, alu_a_sel, 3'b0, alu_b_sel,
                        2'b0, reg_w_sel, 1'b0, mem_r_sel, mem_mask};
        endfunction

        function automatic logic [35:0] en_vec();
                return {30'b0, pc_sel, reg_wen, mem_wen, mem_ren, ebreak, illegal};
        endfunction

        task automatic check_value(input string test, input string what,
                                   input logic [35:0] exp, input logic [35:0] act);
                if (exp !== act) begin
                        $display("MISMATCH %s %s expected %h actual %h", test, what, exp, act);
                        $display("Regression failed");
                        $fatal(1, "stopping at the first error");
                end
        endtask

        task automatic add_test(input string name, input logic [31:0] base,
                                input logic [31:0] fixed, input logic [2:0] fl,
                                input logic [35:0] sel, input logic [5:0] en);
                names[n_tab]  = name;
                bases[n_tab]  = base;
                fixeds[n_tab] = fixed;
                flags[n_tab]  = fl;
                sels[n_tab]   = sel;
                ens[n_tab]    = en;
                n_tab++;
        endtask

        task automatic check_outputs(input int idx);
                if (sels[idx] != DC)
                        check_value(names[idx], "selects", sels[idx], sel_vec());
                check_value(names[idx], "enables", {30'b0, ens[idx]}, en_vec());
        endtask

        task automatic apply_test(input int idx);
                logic [31:0] rnd;
                int          lat;
                random_word(rnd);
                inst = (bases[idx] & fixeds[idx]) | (rnd & ~fixeds[idx]);
                {b_eq, b_lt, b_ltu} = flags[idx];
                req = 1'b1;
                lat = 0;
                do begin
                        @(posedge clk);
                        #2;
                        lat++;
                end while (!ack);
                check_value(names[idx], "ack latency", 36'd1, 36'(lat));
                check_outputs(idx);
                @(posedge clk);
                #2;
                check_value(names[idx], "ack held", 36'd1, {35'b0, ack});
                req = 1'b0;
                random_word(rnd);
                inst = rnd; // outputs must hold while idle
                lat = 0;
                do begin
                        @(posedge clk);
                        #2;
                        lat++;
                end while (ack);
                check_value(names[idx], "ack release", 36'd1, 36'(lat));
                check_outputs(idx);
        endtask

        initial begin
                rst_n = 1'b0;
                req   = 1'b0;
                inst  = '0;
                b_eq  = 1'b0;
                b_lt  = 1'b0;
                b_ltu = 1'b0;
                lfsr  = 32'h91b6;
                n_tab = 0;
                // name, word, fixed bits, {eq,lt,ltu}, {alu,imm,a,b,wb,mr,mask}, {pc,rw,mw,mr,eb,ill}
                add_test("add", 32'h0000_0033, FX_R, 3'b000, 36'h00_0_0_0_0_0_00, 6'b010000);
                add_test("sub", 32'h4000_0033, FX_R, 3'b000, 36'h01_0_0_0_0_0_00, 6'b010000);
                add_test("and", 32'h0000_7033, FX_R, 3'b000, 36'h02_0_0_0_0_0_00, 6'b010000);
                add_test("or", 32'h0000_6033, FX_R, 3'b000, 36'h03_0_0_0_0_0_00, 6'b010000);
                add_test("xor", 32'h0000_4033, FX_R, 3'b000, 36'h04_0_0_0_0_0_00, 6'b010000);
                add_test("sll", 32'h0000_1033, FX_R, 3'b000, 36'h05_0_0_0_0_0_00, 6'b010000);
                add_test("srl", 32'h0000_5033, FX_R, 3'b000, 36'h06_0_0_0_0_0_00, 6'b010000);
                add_test("sra", 32'h4000_5033, FX_R, 3'b000, 36'h07_0_0_0_0_0_00, 6'b010000);
                add_test("slt", 32'h0000_2033, FX_R, 3'b000, 36'h08_0_0_0_0_0_00, 6'b010000);
                add_test("sltu", 32'h0000_3033, FX_R, 3'b000, 36'h09_0_0_0_0_0_00, 6'b010000);
                add_test("addw", 32'h0000_003b, FX_R, 3'b000, 36'h0a_0_0_0_0_0_00, 6'b010000);
                add_test("subw", 32'h4000_003b, FX_R, 3'b000, 36'h0b_0_0_0_0_0_00, 6'b010000);
                add_test("sllw", 32'h0000_103b, FX_R, 3'b000, 36'h0c_0_0_0_0_0_00, 6'b010000);
                add_test("srlw", 32'h0000_503b, FX_R, 3'b000, 36'h0d_0_0_0_0_0_00, 6'b010000);
                add_test("sraw", 32'h4000_503b, FX_R, 3'b000, 36'h0e_0_0_0_0_0_00, 6'b010000);
                add_test("addi", 32'h0000_0013, FX_I, 3'b000, 36'h00_0_0_1_0_0_00, 6'b010000);
                add_test("sltiu", 32'h0000_3013, FX_I, 3'b000, 36'h09_0_0_1_0_0_00, 6'b010000);
                add_test("xori", 32'h0000_4013, FX_I, 3'b000, 36'h04_0_0_1_0_0_00, 6'b010000);
                add_test("andi", 32'h0000_7013, FX_I, 3'b000, 36'h02_0_0_1_0_0_00, 6'b010000);
                add_test("slli", 32'h0000_1013, FX_SH, 3'b000, 36'h05_0_0_1_0_0_00, 6'b010000);
                add_test("srai", 32'h4000_5013, FX_SH, 3'b000, 36'h07_0_0_1_0_0_00, 6'b010000);
                add_test("addiw", 32'h0000_001b, FX_I, 3'b000, 36'h0a_0_0_1_0_0_00, 6'b010000);
                add_test("slliw", 32'h0000_101b, FX_R, 3'b000, 36'h0c_0_0_1_0_0_00, 6'b010000);
                add_test("sraiw", 32'h4000_501b, FX_R, 3'b000, 36'h0e_0_0_1_0_0_00, 6'b010000);
                add_test("lb", 32'h0000_0003, FX_I, 3'b000, 36'h00_0_0_1_1_0_00, 6'b010100);
                add_test("lh", 32'h0000_1003, FX_I, 3'b000, 36'h00_0_0_1_1_1_00, 6'b010100);
                add_test("lw", 32'h0000_2003, FX_I, 3'b000, 36'h00_0_0_1_1_2_00, 6'b010100);
                add_test("ld", 32'h0000_3003, FX_I, 3'b000, 36'h00_0_0_1_1_3_00, 6'b010100);
                add_test("lbu", 32'h0000_4003, FX_I, 3'b000, 36'h00_0_0_1_1_4_00, 6'b010100);
                add_test("lhu", 32'h0000_5003, FX_I, 3'b000, 36'h00_0_0_1_1_5_00, 6'b010100);
                add_test("lwu", 32'h0000_6003, FX_I, 3'b000, 36'h00_0_0_1_1_6_00, 6'b010100);
                add_test("sb", 32'h0000_0023, FX_I, 3'b000, 36'h00_1_0_1_0_0_01, 6'b001000);
                add_test("sh", 32'h0000_1023, FX_I, 3'b000, 36'h00_1_0_1_0_0_03, 6'b001000);
                add_test("sw", 32'h0000_2023, FX_I, 3'b000, 36'h00_1_0_1_0_0_0f, 6'b001000);
                add_test("sd", 32'h0000_3023, FX_I, 3'b000, 36'h00_1_0_1_0_0_ff, 6'b001000);
                add_test("beq_t", 32'h0000_0063, FX_I, 3'b100, 36'h00_2_1_1_0_0_00, 6'b100000);
                add_test("beq_nt", 32'h0000_0063, FX_I, 3'b011, 36'h00_2_1_1_0_0_00, 6'b000000);
                add_test("bne_t", 32'h0000_1063, FX_I, 3'b011, 36'h00_2_1_1_0_0_00, 6'b100000);
                add_test("bne_nt", 32'h0000_1063, FX_I, 3'b100, 36'h00_2_1_1_0_0_00, 6'b000000);
                add_test("blt_t", 32'h0000_4063, FX_I, 3'b010, 36'h00_2_1_1_0_0_00, 6'b100000);
                add_test("blt_nt", 32'h0000_4063, FX_I, 3'b101, 36'h00_2_1_1_0_0_00, 6'b000000);
                add_test("bge_t", 32'h0000_5063, FX_I, 3'b101, 36'h00_2_1_1_0_0_00, 6'b100000);
                add_test("bge_nt", 32'h0000_5063, FX_I, 3'b010, 36'h00_2_1_1_0_0_00, 6'b000000);
                add_test("bltu_t", 32'h0000_6063, FX_I, 3'b001, 36'h00_2_1_1_0_0_00, 6'b100000);
                add_test("bltu_nt", 32'h0000_6063, FX_I, 3'b110, 36'h00_2_1_1_0_0_00, 6'b000000);
                add_test("bgeu_t", 32'h0000_7063, FX_I, 3'b110, 36'h00_2_1_1_0_0_00, 6'b100000);
                add_test("bgeu_nt", 32'h0000_7063, FX_I, 3'b001, 36'h00_2_1_1_0_0_00, 6'b000000);
                add_test("jal", 32'h0000_006f, FX_U, 3'b000, 36'h00_4_1_1_2_0_00, 6'b110000);
                add_test("jalr", 32'h0000_0067, FX_I, 3'b000, 36'h00_0_0_1_2_0_00, 6'b110000);
                add_test("lui", 32'h0000_0037, FX_U, 3'b000, 36'h00_3_2_1_0_0_00, 6'b010000);
                add_test("auipc", 32'h0000_0017, FX_U, 3'b000, 36'h00_3_1_1_0_0_00, 6'b010000);
                add_test("ebreak", `RV_EBREAK_WORD, FX_ALL, 3'b111, DC, 6'b000010);
                add_test("bad_opc", 32'h0000_000b, FX_U, 3'b111, DC, 6'b000001);
                add_test("mul", 32'h0200_0033, FX_R, 3'b111, DC, 6'b000001);
                add_test("ld_f3_7", 32'h0000_7003, FX_I, 3'b111, DC, 6'b000001);
                add_test("bubble", 32'h0000_0000, FX_ALL, 3'b111, DC, 6'b000000);
                repeat (5) @(posedge clk);
                #2;
                rst_n = 1'b1;
                check_value("reset", "ack", 36'd0, {35'b0, ack});
                check_value("reset", "selects", 36'd0, sel_vec());
                check_value("reset", "enables", 36'd0, en_vec());
                for (int i = 0; i < n_tab; i++)
                        apply_test(i);
                $display("Regression passed");
                $finish;
        end
endmodule

/* verilog.f */
+incdir+.
rv_ctrl_pkg.sv
ctrl_if.sv
opcode_decoder.sv
alu_op_decoder.sv
decode_handshake.sv
ctrl_top.sv
ctrl_sva.sv
tb_ctrl_top.sv
